/* Bender.yml */
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - csr_req_if.sv
  - system_decoder.sv
  - csr_file.sv
  - trap_pc_unit.sv
  - csr_unit_top.sv
  - target: test
    files:
      - tb_csr_unit.sv

/* csr_file.sv */
`timescale 1ns/1ps

module csr_file import csr_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  xlen_t  pc_i,
    csr_req_if.csr req,
    output xlen_t  csr_data_o,
    output xlen_t  mtvec_o,
    output xlen_t  mepc_o
);

    xlen_t mstatus;
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;

    logic  sel_mstatus;
    logic  sel_mtvec;
    logic  sel_mepc;
    logic  sel_mcause;

    xlen_t rdata;
    xlen_t wr_data;

    // address match, only while a csr instruction is present
    assign sel_mstatus = req.csr_en && (req.addr == CSR_MSTATUS);
    assign sel_mtvec   = req.csr_en && (req.addr == CSR_MTVEC);
    assign sel_mepc    = req.csr_en && (req.addr == CSR_MEPC);
    assign sel_mcause  = req.csr_en && (req.addr == CSR_MCAUSE);

    // unimplemented addresses read zero
    always_comb begin
        case (req.addr)
            CSR_MSTATUS: rdata = mstatus;
            CSR_MTVEC:   rdata = mtvec;
            CSR_MEPC:    rdata = mepc;
            CSR_MCAUSE:  rdata = mcause;
            default:     rdata = '0;
        endcase
    end

    // old value, before this instruction
    assign csr_data_o = req.csr_en ? rdata : '0;

    // read-modify-write value
    always_comb begin
        case (req.op)
            CSR_OP_WRITE: wr_data = req.operand;
            CSR_OP_SET:   wr_data = rdata | req.operand;
            CSR_OP_CLEAR: wr_data = rdata & ~req.operand;
            default:      wr_data = rdata;
        endcase
    end

    // mstatus: trap entry and return move the interrupt enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= MSTATUS_RESET;
        end else if (req.ecall) begin
            mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]  <= 1'b0;
        end else if (req.mret) begin
            mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
            mstatus[MSTATUS_MPIE] <= 1'b1;
        end else if (sel_mstatus) begin
            mstatus <= wr_data;
        end
    end

    // mtvec, direct mode only so base stays word aligned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= '0;
        end else if (sel_mtvec) begin
            mtvec <= {wr_data[XLEN-1:2], 2'b00};
        end
    end

    // mepc takes the trapping pc on ecall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc <= '0;
        end else if (req.ecall) begin
            mepc <= {pc_i[XLEN-1:2], 2'b00};
        end else if (sel_mepc) begin
            mepc <= {wr_data[XLEN-1:2], 2'b00};
        end
    end

    // mcause, only environment call from m-mode is raised
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause <= '0;
        end else if (req.ecall) begin
            mcause <= CAUSE_ECALL_M;
        end else if (sel_mcause) begin
            mcause <= wr_data;
        end
    end

    // redirect targets for the pc unit
    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;

endmodule

/* csr_pkg.sv */
package csr_pkg;

    // machine word and instruction widths
    localparam int unsigned XLEN       = 64;
    localparam int unsigned INSTR_W    = 32;
    localparam int unsigned CSR_ADDR_W = 12;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // csr operation, same encoding as funct3[1:0]
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    // implemented machine csrs
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // opcode bits 6:2 of the SYSTEM major opcode
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    // funct3 codes, bit 2 marks the immediate forms
    localparam logic [2:0]  F3_PRIV     = 3'b000;
    localparam logic [2:0]  F3_RSVD     = 3'b100;
    localparam int unsigned F3_IMM_BIT  = 2;

    // bits 31:20 of the privileged instructions
    localparam logic [11:0] ECALL_IMM12 = 12'h000;
    localparam logic [11:0] MRET_IMM12  = 12'h302;

    // mstatus fields in use
    localparam int unsigned MSTATUS_MIE  = 3;
    localparam int unsigned MSTATUS_MPIE = 7;

    // uxl = sxl = 2, mpp = 3
    localparam xlen_t MSTATUS_RESET = 64'h0000_000a_0000_1800;

    localparam xlen_t CAUSE_ECALL_M = 64'd11;

    // sequential fetch step
    localparam xlen_t PC_STEP = 64'd4;

endpackage

/* csr_req_if.sv */
`timescale 1ns/1ps

interface csr_req_if import csr_pkg::*; ();

    logic      csr_en;
    csr_op_e   op;
    csr_addr_t addr;
    xlen_t     operand;
    // single-cycle strobes
    logic      ecall;
    logic      mret;

    modport dec (
        output csr_en, op, addr, operand, ecall, mret
    );

    modport csr (
        input csr_en, op, addr, operand, ecall, mret
    );

    // pc unit only needs the control transfers
    modport pc (
        input ecall, mret
    );

endinterface

/* csr_unit_top.sv */
`timescale 1ns/1ps

module csr_unit_top import csr_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  xlen_t  pc_i,
    input  instr_t instr_i,
    input  xlen_t  rs1_data_i,
    output xlen_t  csr_data_o,
    output xlen_t  next_pc_o
);

    xlen_t mtvec;
    xlen_t mepc;

    // decoded request shared by all three blocks
    csr_req_if req_if ();

    system_decoder u_decoder (
        .instr_i    (instr_i),
        .rs1_data_i (rs1_data_i),
        .req        (req_if.dec)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_i       (pc_i),
        .req        (req_if.csr),
        .csr_data_o (csr_data_o),
        .mtvec_o    (mtvec),
        .mepc_o     (mepc)
    );

    // next fetch address, including trap redirects
    trap_pc_unit u_pc_unit (
        .pc_i      (pc_i),
        .mtvec_i   (mtvec),
        .mepc_i    (mepc),
        .req       (req_if.pc),
        .next_pc_o (next_pc_o)
    );

endmodule

/* sources.f */
csr_pkg.sv
csr_req_if.sv
system_decoder.sv
csr_file.sv
trap_pc_unit.sv
csr_unit_top.sv
tb_csr_unit.sv

/* system_decoder.sv */
`timescale 1ns/1ps

module system_decoder import csr_pkg::*; (
    input  instr_t     instr_i,
    input  xlen_t      rs1_data_i,
    csr_req_if.dec     req
);

    logic       is_system;
    logic [2:0] funct3;
    logic [11:0] imm12;
    logic [4:0] rs1_field;
    logic       is_priv;
    logic       is_csr;
    xlen_t      zimm;

    // instruction fields
    assign funct3    = instr_i[14:12];
    assign imm12     = instr_i[31:20];
    assign rs1_field = instr_i[19:15];

    assign is_system = (instr_i[6:2] == OPC_SYSTEM);

    // funct3 of zero holds ecall and mret
    assign is_priv = is_system && (funct3 == F3_PRIV);

    // 100 is not a csr instruction
    assign is_csr = is_system && (funct3 != F3_PRIV) && (funct3 != F3_RSVD);

    // immediate forms use the rs1 field, zero extended
    assign zimm = XLEN'(rs1_field);

    always_comb begin
        req.csr_en  = is_csr;
        req.addr    = imm12;
        req.op      = CSR_OP_NONE;
        req.operand = rs1_data_i;

        if (is_csr) begin
            req.op = csr_op_e'(funct3[1:0]);
        end

        if (funct3[F3_IMM_BIT]) begin
            req.operand = zimm;
        end
    end

    // trap entry and return
    assign req.ecall = is_priv && (imm12 == ECALL_IMM12);
    assign req.mret  = is_priv && (imm12 == MRET_IMM12);

endmodule

/* tb_csr_unit.sv */
`timescale 1ns/1ps

module tb_csr_unit import csr_pkg::*; ();

    localparam int          CLK_PERIOD    = 40;
    localparam int          RESET_CYCLES  = 16;
    localparam int          STIM_CYCLES   = 400;
    localparam int          MAX_CYCLES    = RESET_CYCLES + STIM_CYCLES + 100;
    localparam logic [31:0] SEED          = 32'hf0b6_2cbf;
    localparam logic [6:0]  SYSTEM_OPCODE = 7'b1110011;
    localparam logic [6:0]  OP_IMM_OPCODE = 7'b0010011;
    localparam instr_t      NOP_INSTR     = 32'h0000_0013;

    logic   clk;
    logic   rst_n;
    xlen_t  pc_i;
    instr_t instr_i;
    xlen_t  rs1_data_i;
    xlen_t  csr_data_o;
    xlen_t  next_pc_o;

    // shadow copy of the four machine csrs
    xlen_t m_mstatus;
    xlen_t m_mtvec;
    xlen_t m_mepc;
    xlen_t m_mcause;

    int n_pass;
    int n_fail;
    int cycles;

    csr_addr_t impl_addr [4] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};

    csr_unit_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_i       (pc_i),
        .instr_i    (instr_i),
        .rs1_data_i (rs1_data_i),
        .csr_data_o (csr_data_o),
        .next_pc_o  (next_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
        assert (actual === expected) begin
            n_pass++;
        end else begin
            $display("mismatch %s: expected %h, got %h", name, expected, actual);
            n_fail++;
        end
    endtask

    // drive on the falling edge and sample a quarter period later
    task automatic drive(input xlen_t fetch_pc, input instr_t instr, input xlen_t rs1);
        @(negedge clk);
        pc_i       = fetch_pc;
        instr_i    = instr;
        rs1_data_i = rs1;
        #(CLK_PERIOD / 4);
    endtask

    function automatic xlen_t model_read(input csr_addr_t addr);
        case (addr)
            CSR_MSTATUS: return m_mstatus;
            CSR_MTVEC:   return m_mtvec;
            CSR_MEPC:    return m_mepc;
            CSR_MCAUSE:  return m_mcause;
            default:     return '0;
        endcase
    endfunction

    // mtvec and mepc are word aligned
    task automatic model_write(input csr_addr_t addr, input xlen_t value);
        case (addr)
            CSR_MSTATUS: m_mstatus = value;
            CSR_MTVEC:   m_mtvec   = value & ~64'h3;
            CSR_MEPC:    m_mepc    = value & ~64'h3;
            CSR_MCAUSE:  m_mcause  = value;
            default: ;
        endcase
    endtask

    // one of 001 010 011 101 110 111
    function automatic logic [2:0] rand_funct3();
        int f;
        f = $urandom_range(1, 6);
        return (f >= 4) ? 3'(f + 1) : 3'(f);
    endfunction

    task automatic csr_op(input logic [2:0] funct3, input csr_addr_t addr,
                          input logic [4:0] rs1_field, input xlen_t rs1_data);
        xlen_t operand;
        xlen_t old;
        xlen_t fetch_pc;
        operand  = funct3[2] ? {59'd0, rs1_field} : rs1_data;
        old      = model_read(addr);
        fetch_pc = {$urandom, $urandom};
        drive(fetch_pc, {addr, rs1_field, funct3, 5'd10, SYSTEM_OPCODE}, rs1_data);
        check_value("csr_data_o", csr_data_o, old);
        check_value("next_pc_o", next_pc_o, fetch_pc + 64'd4);
        case (funct3[1:0])
            2'b01: model_write(addr, operand);
            2'b10: model_write(addr, old | operand);
            2'b11: model_write(addr, old & ~operand);
            default: ;
        endcase
    endtask

    // csrrs with a zero operand leaves the register as it is
    task automatic read_all();
        foreach (impl_addr[i]) begin
            csr_op(3'b010, impl_addr[i], 5'd0, '0);
        end
    endtask

    task automatic do_ecall(input xlen_t fetch_pc);
        drive(fetch_pc, {12'h000, 5'd0, 3'b000, 5'd0, SYSTEM_OPCODE}, {$urandom, $urandom});
        check_value("next_pc_o", next_pc_o, m_mtvec);
        check_value("csr_data_o", csr_data_o, '0);
        m_mepc                  = fetch_pc & ~64'h3;
        m_mcause                = 64'd11;
        m_mstatus[MSTATUS_MPIE] = m_mstatus[MSTATUS_MIE];
        m_mstatus[MSTATUS_MIE]  = 1'b0;
    endtask

    task automatic do_mret();
        drive({$urandom, $urandom}, {12'h302, 5'd0, 3'b000, 5'd0, SYSTEM_OPCODE}, '0);
        check_value("next_pc_o", next_pc_o, m_mepc);
        check_value("csr_data_o", csr_data_o, '0);
        m_mstatus[MSTATUS_MIE]  = m_mstatus[MSTATUS_MPIE];
        m_mstatus[MSTATUS_MPIE] = 1'b1;
    endtask

    // anything that is not a csr, ecall or mret instruction
    task automatic other_instr(input instr_t instr);
        xlen_t fetch_pc;
        fetch_pc = {$urandom, $urandom};
        drive(fetch_pc, instr, {$urandom, $urandom});
        check_value("csr_data_o", csr_data_o, '0);
        check_value("next_pc_o", next_pc_o, fetch_pc + 64'd4);
    endtask

    task automatic report_test(input string name, input int fails_at_start);
        $display("test %s finished with %0d errors", name, n_fail - fails_at_start);
    endtask

    initial begin
        int        start_fail;
        csr_addr_t addr;
        instr_t    instr;

        void'($urandom(SEED));
        n_pass     = 0;
        n_fail     = 0;
        rst_n      = 1'b0;
        pc_i       = '0;
        instr_i    = NOP_INSTR;
        rs1_data_i = '0;
        m_mstatus  = MSTATUS_RESET;
        m_mtvec    = '0;
        m_mepc     = '0;
        m_mcause   = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_fail = n_fail;
        read_all();
        // non-SYSTEM instruction whose immediate matches mstatus
        other_instr({CSR_MSTATUS, 13'd0, OP_IMM_OPCODE});
        report_test("reset_values", start_fail);

        start_fail = n_fail;
        repeat (100) begin
            csr_op(rand_funct3(), impl_addr[$urandom_range(0, 3)], 5'($urandom),
                   {$urandom, $urandom});
        end
        read_all();
        report_test("read_modify_write", start_fail);

        start_fail = n_fail;
        repeat (40) begin
            addr = 12'($urandom);
            // keep away from the implemented addresses
            while (addr inside {CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE}) begin
                addr = 12'($urandom);
            end
            csr_op(rand_funct3(), addr, 5'($urandom), {$urandom, $urandom});
        end
        read_all();
        report_test("unimplemented_addr", start_fail);

        start_fail = n_fail;
        repeat (12) begin
            // random mie and mpie going into the trap
            csr_op(3'b001, CSR_MSTATUS, 5'd5, {$urandom, $urandom});
            csr_op(3'b001, CSR_MTVEC, 5'd6, {$urandom, $urandom});
            do_ecall({$urandom, $urandom});
            read_all();
        end
        report_test("ecall", start_fail);

        start_fail = n_fail;
        repeat (12) begin
            csr_op(3'b001, CSR_MSTATUS, 5'd5, {$urandom, $urandom});
            csr_op(3'b001, CSR_MEPC, 5'd7, {$urandom, $urandom});
            do_mret();
            read_all();
        end
        report_test("mret", start_fail);

        start_fail = n_fail;
        for (int k = 0; k < 32; k++) begin
            instr = $urandom;
            // immediate field points at a live csr
            instr[31:20] = impl_addr[(k / 2) % 4];
            if (k % 2 == 0) begin
                if (instr[6:2] == 5'b11100) begin
                    instr[2] = ~instr[2];
                end
            end else begin
                // SYSTEM opcode with the reserved funct3
                instr[14:12] = 3'b100;
                instr[6:0]   = SYSTEM_OPCODE;
            end
            other_instr(instr);
        end
        read_all();
        report_test("other_encodings", start_fail);

        $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* trap_pc_unit.sv */
`timescale 1ns/1ps

module trap_pc_unit import csr_pkg::*; (
    input  xlen_t  pc_i,
    input  xlen_t  mtvec_i,
    input  xlen_t  mepc_i,
    csr_req_if.pc  req,
    output xlen_t  next_pc_o
);

    xlen_t seq_pc;

    // fall-through fetch address
    assign seq_pc = pc_i + PC_STEP;

    // ecall and mret never arrive together
    always_comb begin
        if (req.ecall) begin
            next_pc_o = mtvec_i;
        end else if (req.mret) begin
            next_pc_o = mepc_i;
        end else begin
            next_pc_o = seq_pc;
        end
    end

endmodule
